/* compile.f */
+incdir+sim
logic/obb_pkg.sv
logic/sat_axis_test.sv
logic/contact_select.sv
logic/pipe_stage.sv
logic/obb_collision_top.sv
sim/tb_clock_gen.sv
sim/tb_obb_collision.sv

/* Bender.yml */
package:
  name: obb_collision

sources:
  - files:
      - logic/obb_pkg.sv
      - logic/sat_axis_test.sv
      - logic/contact_select.sv
      - logic/pipe_stage.sv
      - logic/obb_collision_top.sv
  - target: test
    include_dirs:
      - sim
    files:
      - sim/tb_clock_gen.sv
      - sim/tb_obb_collision.sv

/* sim/tb_obb_model.svh */
`ifndef TB_OBB_MODEL_SVH
`define TB_OBB_MODEL_SVH

// Q4.12 cosine and sine in steps of 22.5 degrees
localparam int COS_Q12 [8] = '{4096, 3784, 2896, 1567, 0, -1567, -2896, -3784};
localparam int SIN_Q12 [8] = '{0, 1567, 2896, 3784, 4096, 3784, 2896, 1567};

logic [31:0] lcg_state = 32'hd672d14b;

function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
endfunction

// Upper state bits have the longer period
function automatic int rand_below(input int n);
    return int'((lcg_next() >> 8) % n);
endfunction

// Center in corner units, half dimensions in whole steps of 2^16 corner units
function automatic obb_t build_box(input int cx, input int cy, input int hw, input int hh,
                                   input int ang);
    obb_t box;
    int   ux;
    int   uy;
    int   sgn_u [NUM_CORNERS];
    int   sgn_v [NUM_CORNERS];
    sgn_u = '{1, -1, -1, 1};
    sgn_v = '{1, 1, -1, -1};
    ux = COS_Q12[ang];
    uy = SIN_Q12[ang];
    box = '0;
    box.pos_x = POS_W'(cx * 4);
    box.pos_y = POS_W'(cy * 4);
    box.u_x = AXIS_W'(ux);
    box.u_y = AXIS_W'(uy);
    // v is u turned a quarter turn
    box.v_x = AXIS_W'(-uy);
    box.v_y = AXIS_W'(ux);
    for (int k = 0; k < NUM_CORNERS; k++) begin
        // Axis times half dimension times 2^16, with the Q4.12 scale removed
        box.points[k].x = POINT_W'(cx + sgn_u[k] * ux * hw * 16 - sgn_v[k] * uy * hh * 16);
        box.points[k].y = POINT_W'(cy + sgn_u[k] * uy * hw * 16 + sgn_v[k] * ux * hh * 16);
    end
    box.half_width  = HALF_W'(hw);
    box.half_height = HALF_W'(hh);
    return box;
endfunction

function automatic pen_cand_t axis_cand(input longint lo, input longint hi,
                                        input logic signed [AXIS_W-1:0] ax,
                                        input logic signed [AXIS_W-1:0] ay);
    pen_cand_t c;
    if (hi < lo) begin
        c.pen      = PEN_W'(hi);
        c.normal_x = ax;
        c.normal_y = ay;
    end else begin
        c.pen      = PEN_W'(lo);
        c.normal_x = -ax;
        c.normal_y = -ay;
    end
    return c;
endfunction

// Corners of src measured in the frame of the other box
function automatic side_cands_t ref_side(input obb_t src, input obb_t frame);
    side_cands_t sc;
    longint      cx;
    longint      cy;
    longint      rx;
    longint      ry;
    longint      pu;
    longint      pv;
    longint      min_u;
    longint      max_u;
    longint      min_v;
    longint      max_v;
    longint      half_u;
    longint      half_v;
    cx = longint'(frame.pos_x) >>> POS_TO_POINT_SHIFT;
    cy = longint'(frame.pos_y) >>> POS_TO_POINT_SHIFT;
    for (int k = 0; k < NUM_CORNERS; k++) begin
        rx = longint'(src.points[k].x) - cx;
        ry = longint'(src.points[k].y) - cy;
        pu = (rx * frame.u_x + ry * frame.u_y) >>> AXIS_FRAC_BITS;
        pv = (rx * frame.v_x + ry * frame.v_y) >>> AXIS_FRAC_BITS;
        if (k == 0 || pu < min_u) min_u = pu;
        if (k == 0 || pu > max_u) max_u = pu;
        if (k == 0 || pv < min_v) min_v = pv;
        if (k == 0 || pv > max_v) max_v = pv;
    end
    half_u = longint'(frame.half_width) <<< HALF_DIM_SHIFT;
    half_v = longint'(frame.half_height) <<< HALF_DIM_SHIFT;
    sc.u = axis_cand(half_u - min_u, max_u + half_u, frame.u_x, frame.u_y);
    sc.v = axis_cand(half_v - min_v, max_v + half_v, frame.v_x, frame.v_y);
    return sc;
endfunction

function automatic contact_t ref_contact(input obb_t a, input obb_t b);
    side_cands_t ab;
    side_cands_t ba;
    pen_cand_t   best_u;
    pen_cand_t   best_v;
    pen_cand_t   best;
    contact_t    c;
    ab = ref_side(a, b);
    ba = ref_side(b, a);
    best_u = ab.u;
    if (ba.u.pen < best_u.pen) best_u = ba.u;
    best_v = ab.v;
    if (ba.v.pen < best_v.pen) best_v = ba.v;
    best = best_u;
    if (best_v.pen < best.pen) best = best_v;
    c.collision = (best.pen >= 0);
    c.normal_x  = best.normal_x;
    c.normal_y  = best.normal_y;
    c.pen       = best.pen;
    return c;
endfunction

`endif

/* sim/tb_obb_collision.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_obb_collision
    import obb_pkg::*;
();

    localparam int NUM_FIXED      = 4;
    localparam int NUM_RANDOM     = 200;
    localparam int NUM_BP         = 150;
    localparam int TIMEOUT_CYCLES = 4 * (NUM_FIXED + NUM_RANDOM + NUM_BP) + 100;
    localparam int LATENCY        = 2;
    localparam int DRAIN_LIMIT    = 4 * LATENCY + 4;

    logic     clk;
    logic     rst;
    logic     in_valid;
    logic     in_ready;
    obb_t     box_a;
    obb_t     box_b;
    logic     out_valid;
    logic     out_ready;
    contact_t result;

    // Expected results in transfer order
    contact_t exp_q   [$];
    string    name_q  [$];
    int       cycle_q [$];

    int       cycle;
    int       value_errors;
    int       protocol_errors;
    int       timeouts;
    int       collisions;
    string    cur_name;
    logic     check_latency;
    contact_t exp_c;
    string    exp_name;
    int       exp_cycle;
    obb_t     pair_a;
    obb_t     pair_b;
    logic     fired;
    int       accepted;

    `include "tb_obb_model.svh"

    tb_clock_gen i_clock_gen (
        .clk (clk),
        .rst (rst)
    );

    obb_collision_top i_dut (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .box_a     (box_a),
        .box_b     (box_b),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .result    (result)
    );

    function automatic contact_t contact_of(input bit col, input int nx, input int ny,
                                            input int pen);
        contact_t c;
        c.collision = col;
        c.normal_x  = AXIS_W'(nx);
        c.normal_y  = AXIS_W'(ny);
        c.pen       = PEN_W'(pen);
        return c;
    endfunction

    task automatic finish_run();
        int total;
        total = value_errors + protocol_errors + timeouts;
        $display("Errors: %0d value, %0d protocol, %0d timeout (collisions seen %0d)",
                 value_errors, protocol_errors, timeouts, collisions);
        if (total == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    endtask

    task automatic check_idle(input string name);
        if (out_valid !== 1'b0) begin
            $display("ERROR %s: out_valid expected 0 actual %b", name, out_valid);
            value_errors++;
        end
        if (in_ready !== 1'b1) begin
            $display("ERROR %s: in_ready expected 1 actual %b", name, in_ready);
            value_errors++;
        end
    endtask

    // Hand-worked results guard the model itself
    task automatic check_model(input string name, input contact_t got, input contact_t exp);
        if (got !== exp) begin
            $display("ERROR %s: model expected %0d/%0d/%0d/%0d actual %0d/%0d/%0d/%0d", name,
                     exp.collision, exp.normal_x, exp.normal_y, exp.pen,
                     got.collision, got.normal_x, got.normal_y, got.pen);
            value_errors++;
        end
    endtask

    // Centers kept close enough that roughly half the pairs overlap
    task automatic make_random_pair(output obb_t a, output obb_t b);
        int cx;
        int cy;
        int dx;
        int dy;
        int hw;
        int hh;
        int ang;
        cx = rand_below(800001) - 400000;
        cy = rand_below(800001) - 400000;
        hw = 2 + rand_below(5);
        hh = 2 + rand_below(5);
        ang = rand_below(8);
        a = build_box(cx, cy, hw, hh, ang);
        dx = rand_below(1400001) - 700000;
        dy = rand_below(1400001) - 700000;
        hw = 2 + rand_below(5);
        hh = 2 + rand_below(5);
        ang = rand_below(8);
        b = build_box(cx + dx, cy + dy, hw, hh, ang);
    endtask

    task automatic send_pair(input obb_t a, input obb_t b);
        @(negedge clk);
        box_a = a;
        box_b = b;
        in_valid = 1'b1;
        @(posedge clk);
        while (!in_ready) @(posedge clk);
    endtask

    task automatic drain();
        int waited;
        waited = 0;
        @(negedge clk);
        in_valid = 1'b0;
        out_ready = 1'b1;
        while (exp_q.size() != 0 && waited < DRAIN_LIMIT) begin
            @(posedge clk);
            waited++;
        end
    endtask

    // Cycle count, input monitor and run limit
    always @(posedge clk) begin
        cycle <= cycle + 1;
        if (!rst && in_valid && in_ready) begin
            exp_q.push_back(ref_contact(box_a, box_b));
            name_q.push_back(cur_name);
            cycle_q.push_back(check_latency ? cycle : -1);
        end
        if (cycle >= TIMEOUT_CYCLES) begin
            $display("Timeout: run still busy after %0d cycles", cycle);
            timeouts++;
            finish_run();
        end
    end

    always @(posedge clk) begin
        if (!rst && out_valid && out_ready) begin
            if (exp_q.size() == 0) begin
                $display("Result delivered at cycle %0d with no pair outstanding", cycle);
                protocol_errors++;
            end else begin
                exp_c = exp_q.pop_front();
                exp_name = name_q.pop_front();
                exp_cycle = cycle_q.pop_front();
                if (result.collision !== exp_c.collision) begin
                    $display("ERROR %s: collision expected %0d actual %0d", exp_name,
                             exp_c.collision, result.collision);
                    value_errors++;
                end
                if (result.normal_x !== exp_c.normal_x) begin
                    $display("ERROR %s: normal_x expected %0d actual %0d", exp_name,
                             exp_c.normal_x, result.normal_x);
                    value_errors++;
                end
                if (result.normal_y !== exp_c.normal_y) begin
                    $display("ERROR %s: normal_y expected %0d actual %0d", exp_name,
                             exp_c.normal_y, result.normal_y);
                    value_errors++;
                end
                if (result.pen !== exp_c.pen) begin
                    $display("ERROR %s: pen expected %0d actual %0d", exp_name,
                             exp_c.pen, result.pen);
                    value_errors++;
                end
                if (exp_cycle >= 0 && cycle - exp_cycle != LATENCY) begin
                    $display("ERROR %s: latency expected %0d actual %0d", exp_name,
                             LATENCY, cycle - exp_cycle);
                    value_errors++;
                end
                if (result.collision === 1'b1) collisions++;
            end
        end
    end

    initial begin
        in_valid = 1'b0;
        out_ready = 1'b1;
        box_a = '0;
        box_b = '0;
        cur_name = "reset";
        check_latency = 1'b0;

        while (rst !== 1'b0) begin
            @(negedge clk);
            check_idle("reset");
        end
        @(negedge clk);
        check_idle("after_reset");

        // Identical boxes where the v axis gives the smaller overlap
        cur_name = "coincident";
        check_latency = 1'b1;
        pair_a = build_box(0, 0, 5, 3, 0);
        check_model(cur_name, ref_contact(pair_a, pair_a), contact_of(1, 0, -4096, 393216));
        send_pair(pair_a, pair_a);
        pair_a = build_box(100000, -50000, 5, 3, 0);
        check_model(cur_name, ref_contact(pair_a, pair_a), contact_of(1, 0, -4096, 393216));
        send_pair(pair_a, pair_a);
        drain();

        // Gap of 75712 corner units along x
        cur_name = "separated";
        pair_a = build_box(600000, 0, 4, 4, 0);
        pair_b = build_box(0, 0, 4, 4, 0);
        check_model(cur_name, ref_contact(pair_a, pair_b), contact_of(0, -4096, 0, -75712));
        check_model(cur_name, ref_contact(pair_b, pair_a), contact_of(0, 4096, 0, -75712));
        send_pair(pair_a, pair_b);
        send_pair(pair_b, pair_a);
        drain();

        cur_name = "random";
        for (int n = 0; n < NUM_RANDOM; n++) begin
            make_random_pair(pair_a, pair_b);
            send_pair(pair_a, pair_b);
        end
        drain();

        // Random stalls at the output and gaps at the input
        cur_name = "backpressure";
        check_latency = 1'b0;
        accepted = 0;
        fired = 1'b1;
        while (accepted < NUM_BP) begin
            @(negedge clk);
            out_ready = (rand_below(2) == 1);
            if (fired) begin
                if (rand_below(4) == 0) begin
                    in_valid = 1'b0;
                end else begin
                    make_random_pair(pair_a, pair_b);
                    box_a = pair_a;
                    box_b = pair_b;
                    in_valid = 1'b1;
                end
            end
            @(posedge clk);
            if (in_valid && in_ready) accepted++;
            fired = !in_valid || in_ready;
        end
        drain();

        repeat (5) @(posedge clk);
        if (exp_q.size() != 0) begin
            $display("%0d accepted pairs never produced a result", exp_q.size());
            protocol_errors++;
        end
        finish_run();
    end

endmodule

`default_nettype wire

/* sim/tb_clock_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
    output logic clk,
    output logic rst
);

    localparam int HALF_PERIOD  = 5;
    localparam int RESET_CYCLES = 4;

    initial begin
        clk = 1'b0;
        forever #HALF_PERIOD clk = ~clk;
    end

    // Release reset away from the active edge
    initial begin
        rst = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
    end

endmodule

`default_nettype wire

/* logic/obb_collision_top.sv */
`timescale 1ns/1ps
`default_nettype none

module obb_collision_top
    import obb_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  logic     in_valid,
    output logic     in_ready,
    input  obb_t     box_a,
    input  obb_t     box_b,
    output logic     out_valid,
    input  logic     out_ready,
    output contact_t result
);

    side_cands_t cands_ab;
    side_cands_t cands_ba;
    stage1_t     stage1_in;
    stage1_t     stage1_out;
    logic        s1_valid;
    logic        s1_ready;
    contact_t    contact;

    // Corners of A against the frame of B
    sat_axis_test i_sat_a_on_b (
        .points          (box_a.points),
        .ref_pos_x       (box_b.pos_x),
        .ref_pos_y       (box_b.pos_y),
        .ref_u_x         (box_b.u_x),
        .ref_u_y         (box_b.u_y),
        .ref_v_x         (box_b.v_x),
        .ref_v_y         (box_b.v_y),
        .ref_half_width  (box_b.half_width),
        .ref_half_height (box_b.half_height),
        .cands           (cands_ab)
    );

    // Corners of B against the frame of A
    sat_axis_test i_sat_b_on_a (
        .points          (box_b.points),
        .ref_pos_x       (box_a.pos_x),
        .ref_pos_y       (box_a.pos_y),
        .ref_u_x         (box_a.u_x),
        .ref_u_y         (box_a.u_y),
        .ref_v_x         (box_a.v_x),
        .ref_v_y         (box_a.v_y),
        .ref_half_width  (box_a.half_width),
        .ref_half_height (box_a.half_height),
        .cands           (cands_ba)
    );

    assign stage1_in = '{a_on_b: cands_ab, b_on_a: cands_ba};

    pipe_stage #(
        .payload_t (stage1_t)
    ) i_stage1 (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .in_data   (stage1_in),
        .out_valid (s1_valid),
        .out_ready (s1_ready),
        .out_data  (stage1_out)
    );

    contact_select i_select (
        .cands  (stage1_out),
        .result (contact)
    );

    pipe_stage #(
        .payload_t (contact_t)
    ) i_stage2 (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (s1_valid),
        .in_ready  (s1_ready),
        .in_data   (contact),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_data  (result)
    );

    // Corner reduction inside both axis tests must give ordered extents
    a_extent_order: assert property (
        @(posedge clk) disable iff (rst)
        in_valid |->
            (i_sat_a_on_b.extent.min_u <= i_sat_a_on_b.extent.max_u) &&
            (i_sat_a_on_b.extent.min_v <= i_sat_a_on_b.extent.max_v) &&
            (i_sat_b_on_a.extent.min_u <= i_sat_b_on_a.extent.max_u) &&
            (i_sat_b_on_a.extent.min_v <= i_sat_b_on_a.extent.max_v)
    );

endmodule

`default_nettype wire

/* logic/pipe_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module pipe_stage #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     rst,
    input  logic     in_valid,
    output logic     in_ready,
    input  payload_t in_data,
    output logic     out_valid,
    input  logic     out_ready,
    output payload_t out_data
);

    logic     full;
    payload_t data_q;

    // Accept when empty or when the held entry leaves this cycle
    assign in_ready = ~full | out_ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            full <= 1'b0;
        end else if (in_ready) begin
            full <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid && in_ready) begin
            data_q <= in_data;
        end
    end

    assign out_valid = full;
    assign out_data  = data_q;

    // A stalled entry must stay offered and unchanged
    a_stall_hold: assert property (
        @(posedge clk) disable iff (rst)
        out_valid && !out_ready |=> out_valid && $stable(out_data)
    );

    a_reset_empty: assert property (
        @(posedge clk) rst |=> !out_valid
    );

endmodule

`default_nettype wire

/* logic/contact_select.sv */
`timescale 1ns/1ps
`default_nettype none

module contact_select
    import obb_pkg::*;
(
    input  stage1_t  cands,
    output contact_t result
);

    // Winners per axis across both projection directions
    pen_cand_t best_u;
    pen_cand_t best_v;

    // Overall smallest penetration
    pen_cand_t best;

    // Second candidate replaces the first only when strictly smaller
    function automatic pen_cand_t smaller(
        input pen_cand_t first,
        input pen_cand_t second
    );
        pen_cand_t c;
        c = first;
        if (second.pen < first.pen) begin
            c = second;
        end
        return c;
    endfunction

    // A onto B is the default, B onto A must beat it
    assign best_u = smaller(cands.a_on_b.u, cands.b_on_a.u);
    assign best_v = smaller(cands.a_on_b.v, cands.b_on_a.v);

    // u keeps ties against v
    assign best = smaller(best_u, best_v);

    always_comb begin
        result.pen      = best.pen;
        result.normal_x = best.normal_x;
        result.normal_y = best.normal_y;
        // Any negative penetration means a separating axis exists
        result.collision = ~best.pen[PEN_W-1];
    end

endmodule

`default_nettype wire

/* logic/sat_axis_test.sv */
`timescale 1ns/1ps
`default_nettype none

module sat_axis_test
    import obb_pkg::*;
(
    input  point_t [NUM_CORNERS-1:0] points,
    input  logic signed [POS_W-1:0]  ref_pos_x,
    input  logic signed [POS_W-1:0]  ref_pos_y,
    input  logic signed [AXIS_W-1:0] ref_u_x,
    input  logic signed [AXIS_W-1:0] ref_u_y,
    input  logic signed [AXIS_W-1:0] ref_v_x,
    input  logic signed [AXIS_W-1:0] ref_v_y,
    input  logic signed [HALF_W-1:0] ref_half_width,
    input  logic signed [HALF_W-1:0] ref_half_height,
    output side_cands_t              cands
);

    // Reference center brought down to corner scale
    logic signed [POINT_W-1:0] ref_pt_x;
    logic signed [POINT_W-1:0] ref_pt_y;

    // Per-corner offsets and projections
    logic signed [POINT_W-1:0] rel_x  [NUM_CORNERS];
    logic signed [POINT_W-1:0] rel_y  [NUM_CORNERS];
    logic signed [DOT_W-1:0]   dot_u  [NUM_CORNERS];
    logic signed [DOT_W-1:0]   dot_v  [NUM_CORNERS];
    logic signed [UV_W-1:0]    proj_u [NUM_CORNERS];
    logic signed [UV_W-1:0]    proj_v [NUM_CORNERS];

    uv_extent_t extent;

    // Half dimensions in u/v scale
    logic signed [UV_W-1:0] half_u;
    logic signed [UV_W-1:0] half_v;

    logic signed [PEN_W-1:0] pen_min_u;
    logic signed [PEN_W-1:0] pen_max_u;
    logic signed [PEN_W-1:0] pen_min_v;
    logic signed [PEN_W-1:0] pen_max_v;

    function automatic logic signed [UV_W-1:0] min2(
        input logic signed [UV_W-1:0] a,
        input logic signed [UV_W-1:0] b
    );
        return (b < a) ? b : a;
    endfunction

    function automatic logic signed [UV_W-1:0] max2(
        input logic signed [UV_W-1:0] a,
        input logic signed [UV_W-1:0] b
    );
        return (b > a) ? b : a;
    endfunction

    // Min side normal points against the axis; max side wins only when strictly smaller
    function automatic pen_cand_t pick_side(
        input logic signed [PEN_W-1:0]  pen_min,
        input logic signed [PEN_W-1:0]  pen_max,
        input logic signed [AXIS_W-1:0] ax_x,
        input logic signed [AXIS_W-1:0] ax_y
    );
        pen_cand_t c;
        c.pen      = pen_min;
        c.normal_x = -ax_x;
        c.normal_y = -ax_y;
        if (pen_max < pen_min) begin
            c.pen      = pen_max;
            c.normal_x = ax_x;
            c.normal_y = ax_y;
        end
        return c;
    endfunction

    assign ref_pt_x = POINT_W'(ref_pos_x >>> POS_TO_POINT_SHIFT);
    assign ref_pt_y = POINT_W'(ref_pos_y >>> POS_TO_POINT_SHIFT);

    for (genvar i = 0; i < NUM_CORNERS; i++) begin : g_corner
        assign rel_x[i]  = points[i].x - ref_pt_x;
        assign rel_y[i]  = points[i].y - ref_pt_y;
        assign dot_u[i]  = rel_x[i] * ref_u_x + rel_y[i] * ref_u_y;
        assign dot_v[i]  = rel_x[i] * ref_v_x + rel_y[i] * ref_v_y;
        // Drop the Q4.12 fraction of the axis
        assign proj_u[i] = UV_W'(dot_u[i] >>> AXIS_FRAC_BITS);
        assign proj_v[i] = UV_W'(dot_v[i] >>> AXIS_FRAC_BITS);
    end

    // Pairwise reduction over the four corners
    always_comb begin
        extent.min_u = min2(min2(proj_u[0], proj_u[1]), min2(proj_u[2], proj_u[3]));
        extent.max_u = max2(max2(proj_u[0], proj_u[1]), max2(proj_u[2], proj_u[3]));
        extent.min_v = min2(min2(proj_v[0], proj_v[1]), min2(proj_v[2], proj_v[3]));
        extent.max_v = max2(max2(proj_v[0], proj_v[1]), max2(proj_v[2], proj_v[3]));
    end

    assign half_u = UV_W'(ref_half_width) <<< HALF_DIM_SHIFT;
    assign half_v = UV_W'(ref_half_height) <<< HALF_DIM_SHIFT;

    always_comb begin
        pen_min_u = half_u - extent.min_u;
        pen_max_u = extent.max_u + half_u;
        pen_min_v = half_v - extent.min_v;
        pen_max_v = extent.max_v + half_v;
    end

    assign cands.u = pick_side(pen_min_u, pen_max_u, ref_u_x, ref_u_y);
    assign cands.v = pick_side(pen_min_v, pen_max_v, ref_v_x, ref_v_y);

endmodule

`default_nettype wire

/* logic/obb_pkg.sv */
`default_nettype none

package obb_pkg;

    // Fixed-point widths
    localparam int POS_W   = 24;
    localparam int POINT_W = 22;
    localparam int AXIS_W  = 16;
    localparam int HALF_W  = 7;
    localparam int UV_W    = 24;
    localparam int PEN_W   = 32;

    // Dot product keeps both full products plus the carry of their sum
    localparam int DOT_W = POINT_W + AXIS_W + 1;

    // Scale alignment between positions, corners and u/v space
    localparam int POS_TO_POINT_SHIFT = 2;
    localparam int AXIS_FRAC_BITS     = 12;
    localparam int HALF_DIM_SHIFT     = 16;

    localparam int NUM_CORNERS = 4;

    typedef struct packed {
        logic signed [POINT_W-1:0] x;
        logic signed [POINT_W-1:0] y;
    } point_t;

    // One oriented box, axis components in Q4.12
    typedef struct packed {
        logic signed [POS_W-1:0]  pos_x;
        logic signed [POS_W-1:0]  pos_y;
        logic signed [AXIS_W-1:0] u_x;
        logic signed [AXIS_W-1:0] u_y;
        logic signed [AXIS_W-1:0] v_x;
        logic signed [AXIS_W-1:0] v_y;
        point_t [NUM_CORNERS-1:0] points;
        logic signed [HALF_W-1:0] half_width;
        logic signed [HALF_W-1:0] half_height;
    } obb_t;

    // Projected corner range along the reference axes
    typedef struct packed {
        logic signed [UV_W-1:0] min_u;
        logic signed [UV_W-1:0] max_u;
        logic signed [UV_W-1:0] min_v;
        logic signed [UV_W-1:0] max_v;
    } uv_extent_t;

    typedef struct packed {
        logic signed [PEN_W-1:0]  pen;
        logic signed [AXIS_W-1:0] normal_x;
        logic signed [AXIS_W-1:0] normal_y;
    } pen_cand_t;

    // Best u and v candidates of one projection direction
    typedef struct packed {
        pen_cand_t u;
        pen_cand_t v;
    } side_cands_t;

    // Payload of the first pipe stage
    typedef struct packed {
        side_cands_t a_on_b;
        side_cands_t b_on_a;
    } stage1_t;

    typedef struct packed {
        logic                     collision;
        logic signed [AXIS_W-1:0] normal_x;
        logic signed [AXIS_W-1:0] normal_y;
        logic signed [PEN_W-1:0]  pen;
    } contact_t;

endpackage

`default_nettype wire
